//--- hdl/rw_pkg.sv
// ------------------------------
// Shared widths, types and constants for the read/write engine lane
// Packet and request structs are 65 bits wide, cmd or op in the top bit
// For configuration packets, index[1:0] selects the register
// ------------------------------
package rw_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 16;

    // Element size is 4 bytes
    localparam int ELEM_SHIFT = 2;

    // Both FIFOs share depth and threshold
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // ------------------------------
    // Plain vector types
    // ------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [COUNT_W-1:0] count_t;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic {
        CMD_CONFIG = 1'b0,
        CMD_DATA   = 1'b1
    } pkt_cmd_e;

    typedef enum logic [1:0] {
        CFG_BASE  = 2'd0,
        CFG_COUNT = 2'd1,
        CFG_OP    = 2'd2
    } cfg_sel_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // ------------------------------
    // Structs
    // ------------------------------
    // Incoming packet, index doubles as register select for config
    typedef struct packed {
        pkt_cmd_e cmd;
        addr_t    index;
        data_t    data;
    } mem_packet_t;

    typedef struct packed {
        mem_op_e op;
        addr_t   addr;
        data_t   data;
    } mem_request_t;

    typedef struct packed {
        addr_t   base;
        count_t  count;
        mem_op_e op;
    } rw_config_t;

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/100ps
// ------------------------------
// Single-clock FIFO of DEPTH entries, WIDTH bits each
// dout_o and valid_o follow rd_en_i by one cycle
// Push while full and pop while empty are dropped
// prog_full_o asserts at rw_pkg::PROG_THRESH entries
// ------------------------------
module sync_fifo #(
    parameter int WIDTH = 65,
    parameter int DEPTH = 16
) (
    input  logic             ap_clk_i,
    input  logic             areset_csr_engine_i,
    input  logic             wr_en_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_en_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             valid_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             prog_full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             wr_fire;
    logic             rd_fire;

    // Wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_fire     = wr_en_i && !full_o;
    assign rd_fire     = rd_en_i && !empty_o;
    assign empty_o     = (occupancy == '0);
    assign full_o      = (occupancy == CNT_W'(DEPTH));
    assign prog_full_o = (occupancy >= CNT_W'(rw_pkg::PROG_THRESH));

    always_ff @(posedge ap_clk_i) begin
        if (areset_csr_engine_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= rd_fire;
            if (wr_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_fire, rd_fire})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk_i) begin
        if (wr_fire) begin
            mem[wr_ptr] <= din_i;
        end
        if (rd_fire) begin
            dout_o <= mem[rd_ptr];
        end
    end

    // Callers are expected to respect the flags
    a_no_push_full: assert property (@(posedge ap_clk_i) disable iff (areset_csr_engine_i)
        wr_en_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge ap_clk_i) disable iff (areset_csr_engine_i)
        rd_en_i |-> !empty_o);

endmodule

//--- hdl/packet_router.sv
`timescale 1ns/100ps
// ------------------------------
// Two-way router behind the input FIFO
// Pops only while the output FIFO is below prog_full
// One strobe per packet, one cycle after the FIFO valid
// ------------------------------
module packet_router (
    input  logic                ap_clk_i,
    input  logic                areset_csr_engine_i,
    input  logic                fifo_valid_i,
    input  rw_pkg::mem_packet_t fifo_dout_i,
    input  logic                fifo_empty_i,
    input  logic                out_prog_full_i,
    output logic                fifo_rd_en_o,
    output logic                cfg_valid_o,
    output logic                data_valid_o,
    output rw_pkg::mem_packet_t pkt_o
);

    logic is_config;

    // Back-pressure from the request side
    assign fifo_rd_en_o = !fifo_empty_i && !out_prog_full_i;

    assign is_config = (fifo_dout_i.cmd == rw_pkg::CMD_CONFIG);

    // ------------------------------
    // Strobes
    // ------------------------------
    always_ff @(posedge ap_clk_i) begin
        if (areset_csr_engine_i) begin
            cfg_valid_o  <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            cfg_valid_o  <= fifo_valid_i && is_config;
            data_valid_o <= fifo_valid_i && !is_config;
        end
    end

    // Packet register, shared by both paths
    always_ff @(posedge ap_clk_i) begin
        if (fifo_valid_i) begin
            pkt_o <= fifo_dout_i;
        end
    end

    // The input FIFO only returns a packet that was popped
    a_valid_after_pop: assert property (@(posedge ap_clk_i) disable iff (areset_csr_engine_i)
        fifo_valid_i |-> $past(fifo_rd_en_o));

endmodule

//--- hdl/rw_configure.sv
`timescale 1ns/100ps
// ------------------------------
// Configuration registers: base, count and op
// The count write must come last, it arms the job
// configured_o stays high until reset
// Register select 3 is ignored
// ------------------------------
module rw_configure (
    input  logic                ap_clk_i,
    input  logic                areset_csr_engine_i,
    input  logic                cfg_valid_i,
    input  rw_pkg::mem_packet_t pkt_i,
    output rw_pkg::rw_config_t  config_o,
    output logic                configured_o,
    output logic                job_start_o
);

    rw_pkg::cfg_sel_e cfg_sel;

    assign cfg_sel = rw_pkg::cfg_sel_e'(pkt_i.index[1:0]);

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge ap_clk_i) begin
        if (areset_csr_engine_i) begin
            config_o     <= '0;
            configured_o <= 1'b0;
            job_start_o  <= 1'b0;
        end else begin
            job_start_o <= 1'b0;
            if (cfg_valid_i) begin
                case (cfg_sel)
                    rw_pkg::CFG_BASE: begin
                        config_o.base <= pkt_i.data;
                    end
                    rw_pkg::CFG_COUNT: begin
                        config_o.count <= pkt_i.data[rw_pkg::COUNT_W-1:0];
                        configured_o   <= 1'b1;
                        // New job for the generator
                        job_start_o    <= 1'b1;
                    end
                    rw_pkg::CFG_OP: begin
                        config_o.op <= rw_pkg::mem_op_e'(pkt_i.data[0]);
                    end
                    default: begin
                        config_o <= config_o;
                    end
                endcase
            end
        end
    end

    // Only configuration packets arrive with the strobe
    a_cfg_cmd: assert property (@(posedge ap_clk_i)
        disable iff (areset_csr_engine_i)
        cfg_valid_i |-> (pkt_i.cmd == rw_pkg::CMD_CONFIG));

endmodule

//--- hdl/rw_generator.sv
`timescale 1ns/100ps
// ------------------------------
// Request generator, one request per data packet
// addr = base + (index << ELEM_SHIFT), op and base from the config
// Packets outside an active job are dropped, extras beyond count too
// done_o needs all requests issued and the output FIFO empty
// ------------------------------
module rw_generator (
    input  logic                 ap_clk_i,
    input  logic                 areset_csr_engine_i,
    input  logic                 data_valid_i,
    input  rw_pkg::mem_packet_t  pkt_i,
    input  rw_pkg::rw_config_t   config_i,
    input  logic                 configured_i,
    input  logic                 job_start_i,
    input  logic                 out_fifo_empty_i,
    output logic                 req_push_o,
    output rw_pkg::mem_request_t req_o,
    output logic                 done_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } gen_state_e;

    gen_state_e     state;
    rw_pkg::count_t issued_cnt;
    rw_pkg::count_t cnt_cur;
    rw_pkg::count_t cnt_next;
    logic           active;
    logic           accept;

    // ------------------------------
    // Issue decision
    // ------------------------------
    // A job start may land in the same cycle as its first data packet
    always_comb begin
        cnt_cur  = job_start_i ? '0 : issued_cnt;
        active   = job_start_i || (state == RUN);
        accept   = active && configured_i && data_valid_i && (cnt_cur != config_i.count);
        cnt_next = accept ? cnt_cur + 1'b1 : cnt_cur;
    end

    // ------------------------------
    // FSM and counter
    // ------------------------------
    always_ff @(posedge ap_clk_i) begin
        if (areset_csr_engine_i) begin
            state      <= IDLE;
            issued_cnt <= '0;
            req_push_o <= 1'b0;
            done_o     <= 1'b1;
        end else begin
            req_push_o <= accept;
            issued_cnt <= cnt_next;
            if (active) begin
                done_o <= 1'b0;
                state  <= (cnt_next == config_i.count) ? DRAIN : RUN;
            end else if ((state == DRAIN) && out_fifo_empty_i && !req_push_o) begin
                // Last push has landed and left the FIFO
                state  <= IDLE;
                done_o <= 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge ap_clk_i) begin
        if (accept) begin
            req_o.op   <= config_i.op;
            req_o.addr <= config_i.base + (pkt_i.index << rw_pkg::ELEM_SHIFT);
            req_o.data <= pkt_i.data;
        end
    end

    // Nothing left downstream while done is reported
    a_done_drained: assert property (@(posedge ap_clk_i) disable iff (areset_csr_engine_i)
        done_o |-> out_fifo_empty_i);

endmodule

//--- hdl/engine_read_write.sv
`timescale 1ns/100ps
// ------------------------------
// Read/write engine lane, top level
// Sender must not strobe pkt_valid_i while in_prog_full_o is high
// req_ready_i acts as a read enable, req_valid_o follows a pop by one cycle
// done_o is high out of reset and after each finished job
// ------------------------------
module engine_read_write (
    input  logic                 ap_clk,
    input  logic                 areset_csr_engine,
    input  logic                 pkt_valid_i,
    input  rw_pkg::mem_packet_t  pkt_i,
    input  logic                 req_ready_i,
    output logic                 in_prog_full_o,
    output logic                 req_valid_o,
    output rw_pkg::mem_request_t req_o,
    output logic                 done_o
);

    // Input register
    logic                pkt_valid_q;
    rw_pkg::mem_packet_t pkt_q;

    // Input FIFO
    logic                in_rd_en;
    logic                in_valid;
    logic                in_empty;
    rw_pkg::mem_packet_t in_dout;

    // Router to configuration and generator
    logic                cfg_valid;
    logic                data_valid;
    rw_pkg::mem_packet_t routed_pkt;
    rw_pkg::rw_config_t  config_w;
    logic                configured;
    logic                job_start;

    // Generator to output FIFO
    logic                 req_push;
    rw_pkg::mem_request_t gen_req;
    logic                 out_rd_en;
    logic                 out_empty;
    logic                 out_prog_full;

    // ------------------------------
    // Input register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        pkt_q <= pkt_i;
    end

    sync_fifo #(
        .WIDTH ($bits(rw_pkg::mem_packet_t)),
        .DEPTH (rw_pkg::FIFO_DEPTH         )
    ) i_in_fifo (
        .ap_clk_i            (ap_clk           ),
        .areset_csr_engine_i (areset_csr_engine),
        .wr_en_i             (pkt_valid_q      ),
        .din_i               (pkt_q            ),
        .rd_en_i             (in_rd_en         ),
        .dout_o              (in_dout          ),
        .valid_o             (in_valid         ),
        .empty_o             (in_empty         ),
        .full_o              (                 ),
        .prog_full_o         (in_prog_full_o   )
    );

    packet_router i_router (
        .ap_clk_i            (ap_clk           ),
        .areset_csr_engine_i (areset_csr_engine),
        .fifo_valid_i        (in_valid         ),
        .fifo_dout_i         (in_dout          ),
        .fifo_empty_i        (in_empty         ),
        .out_prog_full_i     (out_prog_full    ),
        .fifo_rd_en_o        (in_rd_en         ),
        .cfg_valid_o         (cfg_valid        ),
        .data_valid_o        (data_valid       ),
        .pkt_o               (routed_pkt       )
    );

    rw_configure i_configure (
        .ap_clk_i            (ap_clk           ),
        .areset_csr_engine_i (areset_csr_engine),
        .cfg_valid_i         (cfg_valid        ),
        .pkt_i               (routed_pkt       ),
        .config_o            (config_w         ),
        .configured_o        (configured       ),
        .job_start_o         (job_start        )
    );

    rw_generator i_generator (
        .ap_clk_i            (ap_clk           ),
        .areset_csr_engine_i (areset_csr_engine),
        .data_valid_i        (data_valid       ),
        .pkt_i               (routed_pkt       ),
        .config_i            (config_w         ),
        .configured_i        (configured       ),
        .job_start_i         (job_start        ),
        .out_fifo_empty_i    (out_empty        ),
        .req_push_o          (req_push         ),
        .req_o               (gen_req          ),
        .done_o              (done_o           )
    );

    // ------------------------------
    // Output FIFO
    // ------------------------------
    assign out_rd_en = req_ready_i && !out_empty;

    sync_fifo #(
        .WIDTH ($bits(rw_pkg::mem_request_t)),
        .DEPTH (rw_pkg::FIFO_DEPTH          )
    ) i_out_fifo (
        .ap_clk_i            (ap_clk           ),
        .areset_csr_engine_i (areset_csr_engine),
        .wr_en_i             (req_push         ),
        .din_i               (gen_req          ),
        .rd_en_i             (out_rd_en        ),
        .dout_o              (req_o            ),
        .valid_o             (req_valid_o      ),
        .empty_o             (out_empty        ),
        .full_o              (                 ),
        .prog_full_o         (out_prog_full    )
    );

endmodule

//--- testbench/tb_engine_read_write.sv
`timescale 1ns/100ps
// ------------------------------
// Random stimulus seeded with 72, DUT inputs driven on the falling edge
// Outputs are sampled on the rising edge against a reference queue
// The run is capped at 4000 cycles
// ------------------------------
module tb_engine_read_write;

    // Stimulus takes well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int BP_COUNT       = 40;

    logic                 ap_clk = 1'b0;
    logic                 areset_csr_engine;
    logic                 pkt_valid_i;
    rw_pkg::mem_packet_t  pkt_i;
    logic                 req_ready_i;
    logic                 in_prog_full_o;
    logic                 req_valid_o;
    rw_pkg::mem_request_t req_o;
    logic                 done_o;

    // Reference model state
    rw_pkg::mem_request_t exp_q[$];
    int                   exp_total    = 0;
    int                   rcv_total    = 0;
    int                   jobs_armed   = 0;
    int                   jobs_started = 0;
    int                   cycle_count  = 0;
    logic                 done_prev    = 1'b1;
    rw_pkg::addr_t        cur_base     = '0;
    rw_pkg::mem_op_e      cur_op       = rw_pkg::OP_READ;
    logic                 hold_ready   = 1'b0;
    logic                 random_ready = 1'b0;

    engine_read_write i_engine_read_write (
        .ap_clk            (ap_clk           ),
        .areset_csr_engine (areset_csr_engine),
        .pkt_valid_i       (pkt_valid_i      ),
        .pkt_i             (pkt_i            ),
        .req_ready_i       (req_ready_i      ),
        .in_prog_full_o    (in_prog_full_o   ),
        .req_valid_o       (req_valid_o      ),
        .req_o             (req_o            ),
        .done_o            (done_o           )
    );

    always #5 ap_clk = ~ap_clk;

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic stop_on_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic stop_on_mismatch(input string name, input logic [31:0] got,
                                    input logic [31:0] expected);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
        stop_on_error("request differs from the reference");
    endtask

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_on_error("timeout, run exceeded the cycle limit");
        end
    end

    // Ready chosen at the rising edge, driven at the next falling edge
    initial begin
        logic next_ready;
        req_ready_i = 1'b0;
        forever begin
            @(posedge ap_clk);
            if (hold_ready) begin
                next_ready = 1'b0;
            end else if (random_ready) begin
                next_ready = (($urandom % 4) != 0);
            end else begin
                next_ready = 1'b1;
            end
            @(negedge ap_clk);
            req_ready_i = next_ready;
        end
    end

    // ------------------------------
    // Output checks
    // ------------------------------
    always @(posedge ap_clk) begin
        rw_pkg::mem_request_t head;
        if (!areset_csr_engine) begin
            // One falling edge of done_o per armed job
            if (done_prev && !done_o) begin
                jobs_started++;
            end
            done_prev = done_o;
            if (req_valid_o) begin
                assert (exp_q.size() > 0)
                    else stop_on_error("request seen with nothing expected");
                head = exp_q.pop_front();
                assert (req_o.op == head.op)
                    else stop_on_mismatch("req_o.op", 32'(req_o.op), 32'(head.op));
                assert (req_o.addr == head.addr)
                    else stop_on_mismatch("req_o.addr", req_o.addr, head.addr);
                assert (req_o.data == head.data)
                    else stop_on_mismatch("req_o.data", req_o.data, head.data);
                rcv_total++;
            end
            // Skipped between a count write and the fall of done_o
            if (done_o && (jobs_started == jobs_armed)) begin
                assert (rcv_total == exp_total)
                    else stop_on_error("done_o high before all requests arrived");
            end
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic drive_packet(input rw_pkg::pkt_cmd_e cmd, input rw_pkg::addr_t index,
                                input rw_pkg::data_t data);
        pkt_valid_i = 1'b1;
        pkt_i.cmd   = cmd;
        pkt_i.index = index;
        pkt_i.data  = data;
    endtask

    // Random data packet, recorded in the reference when a job takes it
    task automatic drive_data(input bit expected);
        rw_pkg::mem_request_t req;
        rw_pkg::addr_t        index;
        rw_pkg::data_t        data;
        index = $urandom;
        data  = $urandom;
        drive_packet(rw_pkg::CMD_DATA, index, data);
        if (expected) begin
            req.op   = cur_op;
            req.addr = cur_base + (index << 2);
            req.data = data;
            exp_q.push_back(req);
            exp_total++;
        end
    endtask

    task automatic wait_room;
        while (in_prog_full_o) begin
            @(negedge ap_clk);
        end
    endtask

    task automatic end_strobe;
        @(negedge ap_clk);
        pkt_valid_i = 1'b0;
    endtask

    task automatic send_config(input rw_pkg::cfg_sel_e sel, input rw_pkg::data_t data);
        wait_room();
        drive_packet(rw_pkg::CMD_CONFIG, 32'(sel), data);
        end_strobe();
    endtask

    task automatic send_data(input bit expected);
        wait_room();
        drive_data(expected);
        end_strobe();
    endtask

    // Count goes last, it starts the job
    task automatic configure_job(input rw_pkg::addr_t base, input rw_pkg::mem_op_e op,
                                 input rw_pkg::count_t count);
        cur_base = base;
        cur_op   = op;
        send_config(rw_pkg::CFG_BASE, base);
        send_config(rw_pkg::CFG_OP, 32'(op));
        jobs_armed++;
        send_config(rw_pkg::CFG_COUNT, 32'(count));
    endtask

    task automatic wait_job_done;
        int n;
        n = 0;
        while ((jobs_started != jobs_armed) && (n < 50)) begin
            @(negedge ap_clk);
            n++;
        end
        assert (jobs_started == jobs_armed)
            else stop_on_error("done_o did not fall after the count write");
        while (!done_o) begin
            @(negedge ap_clk);
        end
        assert ((rcv_total == exp_total) && (exp_q.size() == 0))
            else stop_on_error("job finished with requests missing");
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        bit saw_full;
        int sent;
        int n;
        void'($urandom(72));
        areset_csr_engine = 1'b1;
        pkt_valid_i       = 1'b0;
        pkt_i             = '0;
        saw_full          = 1'b0;
        sent              = 0;
        n                 = 0;
        repeat (16) @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        @(negedge ap_clk);
        assert (done_o && !req_valid_o)
            else stop_on_error("done_o low or req_valid_o high after reset");

        // Unconfigured lane drops data
        repeat (4) send_data(1'b0);
        repeat (20) @(negedge ap_clk);

        configure_job($urandom, rw_pkg::OP_READ, 16'd8);
        repeat (8) send_data(1'b1);
        wait_job_done();

        // Second job with a random ready pattern
        random_ready = 1'b1;
        configure_job($urandom, rw_pkg::OP_WRITE, 16'd8);
        repeat (8) send_data(1'b1);
        wait_job_done();
        random_ready = 1'b0;

        // Back-pressure, send whenever the input has room
        hold_ready = 1'b1;
        configure_job($urandom, rw_pkg::OP_READ, 16'(BP_COUNT));
        repeat (200) begin
            if (!in_prog_full_o && (sent < BP_COUNT)) begin
                drive_data(1'b1);
                sent++;
            end else begin
                pkt_valid_i = 1'b0;
            end
            saw_full = saw_full | in_prog_full_o;
            @(negedge ap_clk);
        end
        pkt_valid_i = 1'b0;
        hold_ready  = 1'b0;
        assert (saw_full) else stop_on_error("in_prog_full_o never rose under back-pressure");
        while (in_prog_full_o && (n < 100)) begin
            @(negedge ap_clk);
            n++;
        end
        assert (!in_prog_full_o)
            else stop_on_error("in_prog_full_o stayed high after ready returned");
        while (sent < BP_COUNT) begin
            send_data(1'b1);
            sent++;
        end
        wait_job_done();

        // Quiet tail, any stray request still trips the output checks
        repeat (10) @(negedge ap_clk);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- src.f
hdl/rw_pkg.sv
hdl/sync_fifo.sv
hdl/packet_router.sv
hdl/rw_configure.sv
hdl/rw_generator.sv
hdl/engine_read_write.sv
testbench/tb_engine_read_write.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the engine_read_write testbench with Verilator
# The exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_engine_read_write \
    -f src.f \
    -o sim_tb

./obj_dir/sim_tb
